// ==== verilog/pinmux_pkg.sv ====
`default_nettype none

package pinmux_pkg;

   //----------------------------------------------------------------------
   // Bus and register widths
   //----------------------------------------------------------------------
   localparam int DATA_W   = 32;     // Bus data and register width
   localparam int BE_W     = 4;      // One enable per byte lane
   localparam int BYTE_W   = 8;      // Bits per byte lane
   localparam int ADDR_W   = 8;      // Byte address
   localparam int IDX_W    = 5;      // Word index
   localparam int ADDR_LSB = 2;      // Word aligned, byte bits dropped

   //----------------------------------------------------------------------
   // Register word indices
   //----------------------------------------------------------------------
   localparam logic [IDX_W-1:0] REG_CHIP_ID   = 5'd0;
   localparam logic [IDX_W-1:0] REG_GPIO_IN   = 5'd2;   // Captured pins, read only
   localparam logic [IDX_W-1:0] REG_GPIO_OUT  = 5'd3;
   localparam logic [IDX_W-1:0] REG_GPIO_DIR  = 5'd4;
   localparam logic [IDX_W-1:0] REG_GPIO_TYPE = 5'd5;
   localparam logic [IDX_W-1:0] REG_INT_STAT  = 5'd9;   // W1C
   localparam logic [IDX_W-1:0] REG_INT_SET   = 5'd10;  // W1S alias of status
   localparam logic [IDX_W-1:0] REG_INT_MASK  = 5'd11;
   localparam logic [IDX_W-1:0] REG_POS_SEL   = 5'd12;
   localparam logic [IDX_W-1:0] REG_NEG_SEL   = 5'd13;

   // Identification word
   localparam logic [15:0] MANU_ID  = 16'h8949;
   localparam logic [7:0]  CHIP_ID  = 8'h02;
   localparam logic [7:0]  CHIP_REV = 8'h01;
   localparam logic [DATA_W-1:0] CHIP_ID_WORD = {MANU_ID, CHIP_ID, CHIP_REV};

   //----------------------------------------------------------------------
   // Shared structs
   //----------------------------------------------------------------------
   typedef struct packed {
      logic              wr;      // Write strobe
      logic              rd;      // Read strobe
      logic              fresh;   // Not yet acknowledged
      logic [IDX_W-1:0]  idx;
      logic [DATA_W-1:0] wdata;
      logic [BE_W-1:0]   be;
   } reg_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] out_data;
      logic [DATA_W-1:0] dir_sel;
      logic [DATA_W-1:0] out_type;
      logic [DATA_W-1:0] posedge_sel;
      logic [DATA_W-1:0] negedge_sel;
   } gpio_cfg_t;

   typedef struct packed {
      logic [DATA_W-1:0] status;
      logic [DATA_W-1:0] mask;
   } gpio_irq_rd_t;

   // Byte enables widened to a bit mask
   function automatic logic [DATA_W-1:0] be_to_mask(input logic [BE_W-1:0] be);
      logic [DATA_W-1:0] m;
      for (int i = 0; i < BE_W; i++)
      begin
         m[i*BYTE_W +: BYTE_W] = {BYTE_W{be[i]}};
      end
      return m;
   endfunction

endpackage

`default_nettype wire

// ==== verilog/pinmux_bus_front.sv ====
`timescale 1ns/1ps
`default_nettype none

module pinmux_bus_front (
   input  wire logic                            mclk,
   input  wire logic                            h_reset_n,
   input  wire logic                            reg_cs,
   input  wire logic                            reg_wr,
   input  wire logic [pinmux_pkg::ADDR_W-1:0]   reg_addr,
   input  wire logic [pinmux_pkg::DATA_W-1:0]   reg_wdata,
   input  wire logic [pinmux_pkg::BE_W-1:0]     reg_be,
   output pinmux_pkg::reg_req_t                 req
);

   logic                            wr_q;
   logic                            rd_q;
   logic [1:0]                      cs_hist;   // [0] last edge, [1] edge before
   logic [pinmux_pkg::IDX_W-1:0]    idx_q;
   logic [pinmux_pkg::DATA_W-1:0]   wdata_q;
   logic [pinmux_pkg::BE_W-1:0]     be_q;

   //----------------------------------------------------------------------
   // Strobes and select history
   //----------------------------------------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         wr_q    <= 1'b0;
         rd_q    <= 1'b0;
         cs_hist <= 2'b00;
      end
      else
      begin
         wr_q    <= reg_cs & reg_wr;
         rd_q    <= reg_cs & ~reg_wr;
         cs_hist <= {cs_hist[0], reg_cs};
      end
   end

   // Payload, only looked at under a strobe
   always_ff @(posedge mclk)
   begin
      idx_q   <= reg_addr[pinmux_pkg::ADDR_LSB +: pinmux_pkg::IDX_W];
      wdata_q <= reg_wdata;
      be_q    <= reg_be;
   end

   always_comb
   begin
      req.wr    = wr_q;
      req.rd    = rd_q;
      req.fresh = ~cs_hist[1];   // Select already up two edges back, acked
      req.idx   = idx_q;
      req.wdata = wdata_q;
      req.be    = be_q;
   end

endmodule

`default_nettype wire

// ==== verilog/pinmux_gpio_cfg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pinmux_gpio_cfg (
   input  wire logic                            mclk,
   input  wire logic                            h_reset_n,
   input  pinmux_pkg::reg_req_t                 req,
   input  wire logic [pinmux_pkg::DATA_W-1:0]   gpio_in_data,     // Raw pad inputs
   output pinmux_pkg::gpio_cfg_t                cfg,
   output logic      [pinmux_pkg::DATA_W-1:0]   gpio_data_in,     // Captured copy
   output logic      [pinmux_pkg::DATA_W-1:0]   gpio_prev_indata  // Second sync stage
);

   pinmux_pkg::gpio_cfg_t            cfg_q;
   logic [pinmux_pkg::DATA_W-1:0]    wmask;
   logic [pinmux_pkg::DATA_W-1:0]    gpio_in_s;    // First sync stage
   logic [pinmux_pkg::DATA_W-1:0]    gpio_in_ss;   // Second sync stage
   logic [pinmux_pkg::DATA_W-1:0]    gpio_cap;

   assign wmask = pinmux_pkg::be_to_mask(req.be);

   //----------------------------------------------------------------------
   // Configuration words, byte lane writes
   //----------------------------------------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         cfg_q <= '0;
      end
      else if (req.wr)
      begin
         case (req.idx)
            pinmux_pkg::REG_GPIO_OUT:
               cfg_q.out_data    <= (cfg_q.out_data & ~wmask) | (req.wdata & wmask);
            pinmux_pkg::REG_GPIO_DIR:
               cfg_q.dir_sel     <= (cfg_q.dir_sel & ~wmask) | (req.wdata & wmask);
            pinmux_pkg::REG_GPIO_TYPE:   // 0 static, 1 waveform
               cfg_q.out_type    <= (cfg_q.out_type & ~wmask) | (req.wdata & wmask);
            pinmux_pkg::REG_POS_SEL:
               cfg_q.posedge_sel <= (cfg_q.posedge_sel & ~wmask) | (req.wdata & wmask);
            pinmux_pkg::REG_NEG_SEL:
               cfg_q.negedge_sel <= (cfg_q.negedge_sel & ~wmask) | (req.wdata & wmask);
            default:
               cfg_q <= cfg_q;   // Other indices not in this bank
         endcase
      end
   end

   assign cfg = cfg_q;

   //----------------------------------------------------------------------
   // Input pins, double sync then capture
   //----------------------------------------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         gpio_in_s  <= '0;
         gpio_in_ss <= '0;
         gpio_cap   <= '0;
      end
      else
      begin
         gpio_in_s  <= gpio_in_data;
         gpio_in_ss <= gpio_in_s;
         gpio_cap   <= gpio_in_ss;   // Pin change visible here on third edge
      end
   end

   // Previous and current values feed edge detect downstream
   assign gpio_prev_indata = gpio_in_ss;
   assign gpio_data_in     = gpio_cap;

endmodule

`default_nettype wire

// ==== verilog/pinmux_gpio_irq.sv ====
`timescale 1ns/1ps
`default_nettype none

module pinmux_gpio_irq (
   input  wire logic                            mclk,
   input  wire logic                            h_reset_n,
   input  pinmux_pkg::reg_req_t                 req,
   input  wire logic [pinmux_pkg::DATA_W-1:0]   gpio_int_event,   // From GPIO control
   output pinmux_pkg::gpio_irq_rd_t             irq_rd,
   output logic                                 gpio_intr
);

   localparam int BW = pinmux_pkg::BYTE_W;

   logic [pinmux_pkg::DATA_W-1:0]    status_q;
   logic [pinmux_pkg::DATA_W-1:0]    status_nxt;
   logic [pinmux_pkg::DATA_W-1:0]    mask_q;
   logic [pinmux_pkg::DATA_W-1:0]    wmask;
   logic                             clr_wr;   // Write to W1C index
   logic                             set_wr;   // Write to W1S alias
   logic                             mask_wr;

   assign clr_wr  = req.wr && (req.idx == pinmux_pkg::REG_INT_STAT);
   assign set_wr  = req.wr && (req.idx == pinmux_pkg::REG_INT_SET);
   assign mask_wr = req.wr && (req.idx == pinmux_pkg::REG_INT_MASK);
   assign wmask   = pinmux_pkg::be_to_mask(req.be);

   //----------------------------------------------------------------------
   // Status next value per lane
   //----------------------------------------------------------------------
   always_comb
   begin
      for (int i = 0; i < pinmux_pkg::BE_W; i++)
      begin
         if (clr_wr && req.be[i])
            status_nxt[i*BW +: BW] = (status_q[i*BW +: BW] & ~req.wdata[i*BW +: BW])
                                     | gpio_int_event[i*BW +: BW];
         else if (set_wr && req.be[i])
            status_nxt[i*BW +: BW] = status_q[i*BW +: BW] | req.wdata[i*BW +: BW]
                                     | gpio_int_event[i*BW +: BW];
         else
            status_nxt[i*BW +: BW] = status_q[i*BW +: BW] | gpio_int_event[i*BW +: BW];
      end
   end

   // Events OR in last so they beat a clear
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         status_q <= '0;
         mask_q   <= '0;
      end
      else
      begin
         status_q <= status_nxt;
         if (mask_wr)
            mask_q <= (mask_q & ~wmask) | (req.wdata & wmask);
      end
   end

   assign irq_rd.status = status_q;
   assign irq_rd.mask   = mask_q;
   assign gpio_intr     = |(status_q & mask_q);   // Single line to the CPU

endmodule

`default_nettype wire

// ==== verilog/pinmux_read_resp.sv ====
`timescale 1ns/1ps
`default_nettype none

module pinmux_read_resp (
   input  wire logic                            mclk,
   input  wire logic                            h_reset_n,
   input  pinmux_pkg::reg_req_t                 req,
   input  pinmux_pkg::gpio_cfg_t                cfg,
   input  wire logic [pinmux_pkg::DATA_W-1:0]   gpio_data_in,
   input  pinmux_pkg::gpio_irq_rd_t             irq_rd,
   output logic      [pinmux_pkg::DATA_W-1:0]   reg_rdata,
   output logic                                 reg_ack
);

   logic [pinmux_pkg::DATA_W-1:0]   rd_word;

   //----------------------------------------------------------------------
   // Read mux, unmapped words read zero
   //----------------------------------------------------------------------
   always_comb
   begin
      case (req.idx)
         pinmux_pkg::REG_CHIP_ID:   rd_word = pinmux_pkg::CHIP_ID_WORD;
         pinmux_pkg::REG_GPIO_IN:   rd_word = gpio_data_in;
         pinmux_pkg::REG_GPIO_OUT:  rd_word = cfg.out_data;
         pinmux_pkg::REG_GPIO_DIR:  rd_word = cfg.dir_sel;
         pinmux_pkg::REG_GPIO_TYPE: rd_word = cfg.out_type;
         pinmux_pkg::REG_INT_STAT:  rd_word = irq_rd.status;
         pinmux_pkg::REG_INT_SET:   rd_word = irq_rd.status;   // Alias reads status
         pinmux_pkg::REG_INT_MASK:  rd_word = irq_rd.mask;
         pinmux_pkg::REG_POS_SEL:   rd_word = cfg.posedge_sel;
         pinmux_pkg::REG_NEG_SEL:   rd_word = cfg.negedge_sel;
         default:                   rd_word = '0;
      endcase
   end

   //----------------------------------------------------------------------
   // Read data and ack, one pulse per request
   //----------------------------------------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         reg_rdata <= '0;
         reg_ack   <= 1'b0;
      end
      else if (req.rd && req.fresh && !reg_ack)
      begin
         reg_rdata <= rd_word;   // Held until next read
         reg_ack   <= 1'b1;
      end
      else if (req.wr && req.fresh && !reg_ack)
      begin
         reg_ack   <= 1'b1;
      end
      else
      begin
         reg_ack   <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/pinmux_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pinmux_reg (
   input  wire logic                            mclk,
   input  wire logic                            h_reset_n,

   // Register bus
   input  wire logic                            reg_cs,
   input  wire logic                            reg_wr,
   input  wire logic [pinmux_pkg::ADDR_W-1:0]   reg_addr,
   input  wire logic [pinmux_pkg::DATA_W-1:0]   reg_wdata,
   input  wire logic [pinmux_pkg::BE_W-1:0]     reg_be,
   output logic      [pinmux_pkg::DATA_W-1:0]   reg_rdata,
   output logic                                 reg_ack,

   // GPIO side
   input  wire logic [pinmux_pkg::DATA_W-1:0]   gpio_in_data,
   input  wire logic [pinmux_pkg::DATA_W-1:0]   gpio_int_event,
   output pinmux_pkg::gpio_cfg_t                cfg_gpio,
   output logic      [pinmux_pkg::DATA_W-1:0]   cfg_gpio_data_in,
   output logic      [pinmux_pkg::DATA_W-1:0]   gpio_prev_indata,
   output logic                                 gpio_intr
);

   pinmux_pkg::reg_req_t       req;      // Registered bus request
   pinmux_pkg::gpio_irq_rd_t   irq_rd;   // Status and mask for reads

   //----------------------------------------------------------------------
   // Bus front end
   //----------------------------------------------------------------------
   pinmux_bus_front u_bus_front (
      .mclk        (mclk),
      .h_reset_n   (h_reset_n),
      .reg_cs      (reg_cs),
      .reg_wr      (reg_wr),
      .reg_addr    (reg_addr),
      .reg_wdata   (reg_wdata),
      .reg_be      (reg_be),
      .req         (req)
   );

   // GPIO configuration bank
   pinmux_gpio_cfg u_gpio_cfg (
      .mclk               (mclk),
      .h_reset_n          (h_reset_n),
      .req                (req),
      .gpio_in_data       (gpio_in_data),
      .cfg                (cfg_gpio),
      .gpio_data_in       (cfg_gpio_data_in),
      .gpio_prev_indata   (gpio_prev_indata)
   );

   // Interrupt bank
   pinmux_gpio_irq u_gpio_irq (
      .mclk             (mclk),
      .h_reset_n        (h_reset_n),
      .req              (req),
      .gpio_int_event   (gpio_int_event),
      .irq_rd           (irq_rd),
      .gpio_intr        (gpio_intr)
   );

   // Read data and acknowledge
   pinmux_read_resp u_read_resp (
      .mclk           (mclk),
      .h_reset_n      (h_reset_n),
      .req            (req),
      .cfg            (cfg_gpio),
      .gpio_data_in   (cfg_gpio_data_in),
      .irq_rd         (irq_rd),
      .reg_rdata      (reg_rdata),
      .reg_ack        (reg_ack)
   );

endmodule

`default_nettype wire

// ==== sim/tb_pinmux_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pinmux_reg;

   logic                    mclk;
   logic                    h_reset_n;
   logic                    reg_cs;
   logic                    reg_wr;
   logic [7:0]              reg_addr;
   logic [31:0]             reg_wdata;
   logic [3:0]              reg_be;
   logic [31:0]             reg_rdata;
   logic                    reg_ack;
   logic [31:0]             gpio_in_data;
   logic [31:0]             gpio_int_event;
   pinmux_pkg::gpio_cfg_t   cfg_gpio;
   logic [31:0]             cfg_gpio_data_in;
   logic [31:0]             gpio_prev_indata;
   logic                    gpio_intr;

   int unsigned   lcg_state = 54;
   int            errors = 0;
   int            checks = 0;
   int            test_errors = 0;   // Error count when current test began
   int            tests = 0;
   int            xfers = 0;         // Transactions issued
   int            acks = 0;          // Cycles that saw reg_ack high
   logic          timed_out = 1'b0;
   logic [31:0]   exp_cfg [5];       // Model of the five config words
   logic [31:0]   exp_stat;
   logic [31:0]   exp_mask;
   logic [31:0]   exp_in;
   logic [31:0]   rd;
   logic [31:0]   w;
   logic [3:0]    be;
   logic [4:0]    unmapped [4] = '{5'd1, 5'd6, 5'd16, 5'd31};

   pinmux_reg u_dut (
      .mclk               (mclk),
      .h_reset_n          (h_reset_n),
      .reg_cs             (reg_cs),
      .reg_wr             (reg_wr),
      .reg_addr           (reg_addr),
      .reg_wdata          (reg_wdata),
      .reg_be             (reg_be),
      .reg_rdata          (reg_rdata),
      .reg_ack            (reg_ack),
      .gpio_in_data       (gpio_in_data),
      .gpio_int_event     (gpio_int_event),
      .cfg_gpio           (cfg_gpio),
      .cfg_gpio_data_in   (cfg_gpio_data_in),
      .gpio_prev_indata   (gpio_prev_indata),
      .gpio_intr          (gpio_intr)
   );

   initial mclk = 1'b0;
   always #50 mclk = ~mclk;   // 100 ns period

   // Ack high cycles over whole run, sampled mid cycle
   always @(negedge mclk)
   begin
      if (reg_ack)
         acks++;
   end

   initial
   begin
      wait (timed_out === 1'b1);
      $display("Bus transaction got no reg_ack within 20 cycles");
      $display("Finished with errors");
      $finish;
   end

   //----------------------------------------------------------------------
   // Helpers
   //----------------------------------------------------------------------
   // Two LCG steps, upper halves only
   function automatic logic [31:0] lcg_next();
      logic [15:0] hi;
      lcg_state = lcg_state * 1103515245 + 12345;
      hi        = lcg_state[31:16];
      lcg_state = lcg_state * 1103515245 + 12345;
      return {hi, lcg_state[31:16]};
   endfunction

   function automatic logic [31:0] lane_mask(input logic [3:0] lanes);
      logic [31:0] m;
      for (int l = 0; l < 4; l++)
         m[l*8 +: 8] = {8{lanes[l]}};
      return m;
   endfunction

   function automatic logic [4:0] cfg_index(input int k);
      case (k)
         0:       return 5'd3;    // Output data
         1:       return 5'd4;    // Direction
         2:       return 5'd5;    // Output type
         3:       return 5'd12;   // Posedge select
         default: return 5'd13;   // Negedge select
      endcase
   endfunction

   function automatic logic [31:0] cfg_field(input int k);
      case (k)
         0:       return cfg_gpio.out_data;
         1:       return cfg_gpio.dir_sel;
         2:       return cfg_gpio.out_type;
         3:       return cfg_gpio.posedge_sel;
         default: return cfg_gpio.negedge_sel;
      endcase
   endfunction

   task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp)
      else
      begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   // Starts and ends on a falling edge
   task automatic bus_xfer(input logic wr, input logic [4:0] idx, input logic [31:0] data,
                           input logic [3:0] lanes, output logic [31:0] rdata);
      int waited;
      waited    = 0;
      reg_cs    = 1'b1;
      reg_wr    = wr;
      reg_addr  = {1'b0, idx, 2'b00};
      reg_wdata = data;
      reg_be    = lanes;
      @(negedge mclk);
      while (!reg_ack && waited < 20)
      begin
         @(negedge mclk);
         waited++;
      end
      if (!reg_ack)
         timed_out = 1'b1;
      rdata  = reg_rdata;
      reg_cs = 1'b0;
      xfers++;
      @(negedge mclk);                         // Idle cycle
      check_eq("ack_one_cycle", 1'b0, reg_ack);
   endtask

   task automatic write_reg(input logic [4:0] idx, input logic [31:0] data,
                            input logic [3:0] lanes);
      logic [31:0] unused;
      bus_xfer(1'b1, idx, data, lanes, unused);
   endtask

   task automatic read_reg(input logic [4:0] idx, output logic [31:0] data);
      bus_xfer(1'b0, idx, 32'h0, 4'hF, data);
   endtask

   // Every readable register against the model
   task automatic verify_regs(input string name);
      logic [31:0] v;
      for (int k = 0; k < 5; k++)
      begin
         read_reg(cfg_index(k), v);
         check_eq(name, exp_cfg[k], v);
         check_eq(name, exp_cfg[k], cfg_field(k));
      end
      read_reg(5'd9, v);
      check_eq(name, exp_stat, v);
      read_reg(5'd11, v);
      check_eq(name, exp_mask, v);
      read_reg(5'd2, v);
      check_eq(name, exp_in, v);
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("Test %s done, %0d errors", name, errors - test_errors);
      test_errors = errors;
   endtask

   //----------------------------------------------------------------------
   // Test sequence
   //----------------------------------------------------------------------
   initial
   begin
      h_reset_n      = 1'b0;
      reg_cs         = 1'b0;
      reg_wr         = 1'b0;
      reg_addr       = '0;
      reg_wdata      = '0;
      reg_be         = '0;
      gpio_in_data   = '0;
      gpio_int_event = '0;
      for (int k = 0; k < 5; k++)
         exp_cfg[k] = '0;
      exp_stat = '0;
      exp_mask = '0;
      exp_in   = '0;
      repeat (2) @(negedge mclk);
      h_reset_n = 1'b1;

      // Reset values and chip ID
      check_eq("reset_ack", 1'b0, reg_ack);
      check_eq("reset_rdata", 32'h0, reg_rdata);
      check_eq("reset_cfg", 32'h0, {31'd0, |cfg_gpio});
      check_eq("reset_intr", 1'b0, gpio_intr);
      read_reg(5'd0, rd);
      check_eq("chip_id", 32'h8949_0201, rd);
      end_test("reset_and_id");

      // Full write, then partial byte lanes
      for (int k = 0; k < 5; k++)
      begin
         w = lcg_next();
         write_reg(cfg_index(k), w, 4'hF);
         exp_cfg[k] = w;
         check_eq("cfg_full_field", exp_cfg[k], cfg_field(k));
         read_reg(cfg_index(k), rd);
         check_eq("cfg_full_read", exp_cfg[k], rd);
         w  = lcg_next();
         be = w[3:0];
         w  = lcg_next();
         write_reg(cfg_index(k), w, be);
         exp_cfg[k] = (exp_cfg[k] & ~lane_mask(be)) | (w & lane_mask(be));
         check_eq("cfg_lane_field", exp_cfg[k], cfg_field(k));
         read_reg(cfg_index(k), rd);
         check_eq("cfg_lane_read", exp_cfg[k], rd);
      end
      end_test("cfg_write_readback");

      // Input pins through sync and capture
      exp_in       = lcg_next();
      gpio_in_data = exp_in;
      repeat (4) @(negedge mclk);
      check_eq("sync_captured", exp_in, cfg_gpio_data_in);
      check_eq("sync_prev", exp_in, gpio_prev_indata);
      read_reg(5'd2, rd);
      check_eq("sync_read", exp_in, rd);
      end_test("input_sync");

      // One cycle event pulse
      exp_stat       = lcg_next();
      gpio_int_event = exp_stat;
      @(negedge mclk);
      gpio_int_event = '0;
      read_reg(5'd9, rd);
      check_eq("stat_event", exp_stat, rd);
      read_reg(5'd10, rd);
      check_eq("stat_alias", exp_stat, rd);
      w  = lcg_next();
      be = (w[3:0] | 4'b0001) & 4'b0111;   // Never all lanes
      w  = lcg_next();
      write_reg(5'd9, w, be);
      exp_stat = exp_stat & ~(w & lane_mask(be));
      read_reg(5'd9, rd);
      check_eq("stat_clear", exp_stat, rd);
      w = lcg_next();
      write_reg(5'd10, w, 4'hF);
      exp_stat = exp_stat | w;
      read_reg(5'd10, rd);
      check_eq("stat_set", exp_stat, rd);
      // Event held across a full clear
      w              = lcg_next();
      gpio_int_event = w;
      write_reg(5'd9, 32'hFFFF_FFFF, 4'hF);
      gpio_int_event = '0;
      exp_stat       = w;
      read_reg(5'd9, rd);
      check_eq("stat_event_wins", exp_stat, rd);
      end_test("int_status");

      // Interrupt line vs status and mask, status nonzero here
      exp_mask = exp_stat;
      write_reg(5'd11, exp_mask, 4'hF);
      check_eq("intr_overlap", 1'b1, gpio_intr);
      exp_mask = ~exp_stat;
      write_reg(5'd11, exp_mask, 4'hF);
      check_eq("intr_disjoint", 1'b0, gpio_intr);
      exp_mask = 32'hFFFF_FFFF;
      write_reg(5'd11, exp_mask, 4'hF);
      check_eq("intr_all_mask", 1'b1, gpio_intr);
      write_reg(5'd9, 32'hFFFF_FFFF, 4'hF);
      exp_stat = '0;
      check_eq("intr_cleared", 1'b0, gpio_intr);
      end_test("int_line");

      // Dropped indices read zero, writes go nowhere
      for (int k = 0; k < 4; k++)
      begin
         read_reg(unmapped[k], rd);
         check_eq("unmapped_read", 32'h0, rd);
         write_reg(unmapped[k], lcg_next(), 4'hF);
      end
      verify_regs("unmapped_write");
      check_eq("ack_count", xfers, acks);
      end_test("unmapped_and_ack");

      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/pinmux_pkg.sv
verilog/pinmux_bus_front.sv
verilog/pinmux_gpio_cfg.sv
verilog/pinmux_gpio_irq.sv
verilog/pinmux_read_resp.sv
verilog/pinmux_reg.sv
sim/tb_pinmux_reg.sv
